//--- design/div_unit.sv
// Iterative RV32M divider
// Restoring shift-subtract on operand magnitudes, one quotient bit per
// cycle. A fixup state restores the signs, picks quotient or remainder and
// forces the RISC-V results for divide by zero and signed overflow

`timescale 1ns/1ps
`include "rv32m_consts.svh"

module div_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  new_request,
    input  rv32m_pkg::m_request_t req,
    output logic                  ready,
    output logic                  done,
    output rv32m_pkg::m_result_t  result,
    input  logic                  accepted
);

    import rv32m_pkg::*;

    localparam int CNT_W = $clog2(`M_DIV_CYCLES);
    localparam xlen_t MOST_NEG = {1'b1, {(`M_XLEN-1){1'b0}}};   // 0x80000000

    typedef enum logic [1:0] {
        IDLE,                               // Waiting for a request
        RUN,                                // Shift-subtract iterations
        FIXUP,                              // Sign and special-case correction
        DONE                                // Result held for writeback
    } div_state_e;

    div_state_e state;
    logic [CNT_W-1:0] count;                // Iterations left after this one

    logic   is_signed;                      // DIV and REM treat operands as signed
    logic   neg_a;                          // Dividend is negative
    logic   neg_b;                          // Divisor is negative

    xlen_t  rem_r;                          // Partial remainder
    xlen_t  quo_r;                          // Dividend bits shift out, quotient bits in
    xlen_t  divisor_r;                      // Divisor magnitude
    xlen_t  dividend_r;                     // Original dividend for the special cases
    inst_id_t id_r;
    logic   sel_rem;                        // REM or REMU
    logic   neg_q;                          // Quotient needs negation
    logic   neg_r;                          // Remainder needs negation
    logic   div_zero;                       // Divisor was zero
    logic   overflow;                       // Most negative divided by minus one
    xlen_t  result_r;                       // Final value presented with done

    logic [`M_XLEN+1:0] trial;              // Shifted remainder minus divisor, MSB is borrow
    xlen_t  q_fix;
    xlen_t  r_fix;

    assign is_signed = ~req.op[0];
    assign neg_a     = is_signed & req.rs1[`M_XLEN-1];
    assign neg_b     = is_signed & req.rs2[`M_XLEN-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (new_request) state <= RUN;
                RUN:     if (count == '0) state <= FIXUP;
                FIXUP:   state <= DONE;
                DONE:    if (accepted) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Top dividend bit joins the remainder, the divisor is tried against it
    assign trial = {1'b0, rem_r, quo_r[`M_XLEN-1]} - {2'b00, divisor_r};

    always_ff @(posedge clk) begin
        if (state == IDLE && new_request) begin
            count      <= CNT_W'(`M_DIV_CYCLES - 1);
            rem_r      <= '0;
            quo_r      <= neg_a ? -req.rs1 : req.rs1;
            divisor_r  <= neg_b ? -req.rs2 : req.rs2;
            dividend_r <= req.rs1;
            id_r       <= req.id;
            sel_rem    <= req.op[1];
            neg_q      <= neg_a ^ neg_b;
            neg_r      <= neg_a;        // Remainder follows the dividend sign
            div_zero   <= (req.rs2 == '0);
            overflow   <= is_signed & (req.rs1 == MOST_NEG) & (req.rs2 == '1);
        end else if (state == RUN) begin
            count <= count - 1'b1;
            if (trial[`M_XLEN+1]) begin
                rem_r <= {rem_r[`M_XLEN-2:0], quo_r[`M_XLEN-1]};    // Restore
            end else begin
                rem_r <= trial[`M_XLEN-1:0];
            end
            quo_r <= {quo_r[`M_XLEN-2:0], ~trial[`M_XLEN+1]};
        end else if (state == FIXUP) begin
            result_r <= sel_rem ? r_fix : q_fix;
        end
    end

    // RISC-V fixes both special cases to defined values instead of trapping
    always_comb begin
        q_fix = neg_q ? -quo_r : quo_r;
        r_fix = neg_r ? -rem_r : rem_r;
        if (div_zero) begin
            q_fix = '1;
            r_fix = dividend_r;
        end else if (overflow) begin
            q_fix = dividend_r;
            r_fix = '0;
        end
    end

    assign ready  = (state == IDLE);        // One division in flight at a time
    assign done   = (state == DONE);
    assign result = '{rd: result_r, id: id_r};

endmodule

//--- design/m_ext_unit.sv
// RV32M multiply/divide execute cluster
// Issue dispatch feeds a pipelined multiplier and an iterative divider,
// whose results merge through a writeback arbiter into one output port

`timescale 1ns/1ps

module m_ext_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue_valid,
    input  rv32m_pkg::m_request_t issue_req,
    output logic                  issue_ready,
    output logic                  result_valid,
    output rv32m_pkg::m_result_t  result,
    input  logic                  result_ready
);

    import rv32m_pkg::*;

    logic       mul_ready;
    logic       div_ready;
    logic       mul_new_request;
    logic       div_new_request;
    m_request_t unit_req;                   // Shared request bundle for both units
    logic       mul_done;
    logic       div_done;
    m_result_t  mul_result;
    m_result_t  div_result;
    logic       mul_accepted;
    logic       div_accepted;

    m_op_dispatch u_dispatch (
        .clk             (clk),
        .rst             (rst),
        .issue_valid     (issue_valid),
        .issue_req       (issue_req),
        .issue_ready     (issue_ready),
        .mul_ready       (mul_ready),
        .div_ready       (div_ready),
        .mul_new_request (mul_new_request),
        .div_new_request (div_new_request),
        .unit_req        (unit_req)
    );

    mul_unit u_mul (
        .clk         (clk),
        .rst         (rst),
        .new_request (mul_new_request),
        .req         (unit_req),
        .ready       (mul_ready),
        .done        (mul_done),
        .result      (mul_result),
        .accepted    (mul_accepted)
    );

    div_unit u_div (
        .clk         (clk),
        .rst         (rst),
        .new_request (div_new_request),
        .req         (unit_req),
        .ready       (div_ready),
        .done        (div_done),
        .result      (div_result),
        .accepted    (div_accepted)
    );

    m_writeback_arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .mul_done     (mul_done),
        .div_done     (div_done),
        .mul_result   (mul_result),
        .div_result   (div_result),
        .mul_accepted (mul_accepted),
        .div_accepted (div_accepted),
        .result_valid (result_valid),
        .result       (result),
        .result_ready (result_ready)
    );

endmodule

//--- design/m_op_dispatch.sv
// M-extension issue stage
// Steers each request to the multiplier or the divider from funct3 bit 2
// and returns the ready of the unit it targets. A transfer fires a one
// cycle strobe to that unit

`timescale 1ns/1ps

module m_op_dispatch (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_valid,
    input  rv32m_pkg::m_request_t  issue_req,
    output logic                   issue_ready,
    input  logic                   mul_ready,
    input  logic                   div_ready,
    output logic                   mul_new_request,
    output logic                   div_new_request,
    output rv32m_pkg::m_request_t  unit_req
);

    logic        sel_div;                   // High for DIV, DIVU, REM and REMU
    logic        issue_fire;                // Issue handshake completes this cycle

    assign sel_div = issue_req.op[2];       // Divide group sits in the upper half of funct3

    // Ready follows only the unit that would take this request
    assign issue_ready = sel_div ? div_ready : mul_ready;
    assign issue_fire  = issue_valid & issue_ready;

    // Both units see the same bundle, the strobe says which one owns it
    assign mul_new_request = issue_fire & ~sel_div;
    assign div_new_request = issue_fire & sel_div;
    assign unit_req        = issue_req;

endmodule

//--- design/m_writeback_arbiter.sv
// M-extension writeback arbiter
// Merges the multiplier and divider result streams into one registered
// output slot. Grants are registered, so a unit sees accepted one cycle
// after the grant decision and its result loads on that same edge.
// The divider wins when both are done

`timescale 1ns/1ps

module m_writeback_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mul_done,
    input  logic                 div_done,
    input  rv32m_pkg::m_result_t mul_result,
    input  rv32m_pkg::m_result_t div_result,
    output logic                 mul_accepted,
    output logic                 div_accepted,
    output logic                 result_valid,
    output rv32m_pkg::m_result_t result,
    input  logic                 result_ready
);

    logic load;                             // Slot takes a unit result this edge
    logic slot_free_next;                   // Slot is guaranteed empty after this edge

    assign load = mul_accepted | div_accepted;

    // A grant is only issued when the slot will be empty at the load edge,
    // which keeps a granted result from ever waiting on back-pressure
    assign slot_free_next = ~load & (~result_valid | result_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            mul_accepted <= 1'b0;
            div_accepted <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            div_accepted <= div_done & slot_free_next;
            mul_accepted <= mul_done & ~div_done & slot_free_next;
            if (load) begin
                result_valid <= 1'b1;
            end else if (result_ready) begin
                result_valid <= 1'b0;       // Consumed with nothing behind it
            end
        end
    end

    // Units hold their result until they see accepted, so it is still there
    always_ff @(posedge clk) begin
        if (load) begin
            result <= div_accepted ? div_result : mul_result;
        end
    end

endmodule

//--- design/mul_unit.sv
// Two-stage RV32M multiplier
// Stage 1 registers sign-extended 33-bit operands, stage 2 registers the
// 66-bit signed product. The output presents the high or low word and
// holds it with done until the writeback arbiter accepts it

`timescale 1ns/1ps
`include "rv32m_consts.svh"

module mul_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  new_request,
    input  rv32m_pkg::m_request_t req,
    output logic                  ready,
    output logic                  done,
    output rv32m_pkg::m_result_t  result,
    input  logic                  accepted
);

    import rv32m_pkg::*;

    logic [1:0] valid;                      // Occupancy of stage 1 and stage 2
    logic [1:0] advance;                    // Stage may load new contents this cycle

    logic rs1_signed;                       // Top bit of rs1 extends as a sign
    logic rs2_signed;                       // Top bit of rs2 extends as a sign
    logic take_high;                        // Request wants bits 63:32 of the product

    logic signed [`M_XLEN:0] rs1_ext;       // 33-bit operands so one signed
    logic signed [`M_XLEN:0] rs2_ext;       // multiplier covers all four ops
    logic signed [`M_XLEN:0] rs1_r;
    logic signed [`M_XLEN:0] rs2_r;
    logic signed [2*`M_XLEN+1:0] product;   // 66 bits, only the low 64 are meaningful

    logic     [1:0] mulh;                   // Take-high flag for each stage
    inst_id_t [1:0] id_pipe;                // Tag for each stage
    xlen_t          word_out;               // Selected half of the product

    // Stage 2 drains on accept or when empty, stage 1 follows it
    assign advance[1] = accepted | ~valid[1];
    assign advance[0] = ~valid[0] | advance[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 2'b00;
        end else begin
            if (advance[0]) begin
                valid[0] <= new_request;
            end
            if (advance[1]) begin
                valid[1] <= valid[0];
            end
        end
    end

    // MULHU is the only op with unsigned rs1, MUL and MULH take a signed rs2
    assign rs1_signed = (req.op != MULHU);
    assign rs2_signed = (req.op == MUL) | (req.op == MULH);
    assign take_high  = (req.op != MUL);

    assign rs1_ext = {req.rs1[`M_XLEN-1] & rs1_signed, req.rs1};
    assign rs2_ext = {req.rs2[`M_XLEN-1] & rs2_signed, req.rs2};

    // Ready is granted only when stage 1 can load, so new_request implies advance[0]
    always_ff @(posedge clk) begin
        if (new_request) begin
            rs1_r      <= rs1_ext;
            rs2_r      <= rs2_ext;
            mulh[0]    <= take_high;
            id_pipe[0] <= req.id;
        end
        if (advance[1]) begin
            product    <= rs1_r * rs2_r;    // Full signed product of the extended operands
            mulh[1]    <= mulh[0];
            id_pipe[1] <= id_pipe[0];
        end
    end

    assign word_out = mulh[1] ? product[2*`M_XLEN-1:`M_XLEN] : product[`M_XLEN-1:0];

    // Blocked only when both stages hold work and nothing leaves
    assign ready  = accepted | ~(&valid);
    assign done   = valid[1];
    assign result = '{rd: word_out, id: id_pipe[1]};

endmodule

//--- design/rv32m_consts.svh
// RV32M execute cluster constants
// Widths fixed by the ISA and the iteration count of the radix-2 divider
// Shared by the package and by every RTL block that sizes a vector

`ifndef RV32M_CONSTS_SVH
`define RV32M_CONSTS_SVH

// Integer register width of RV32
`define M_XLEN 32

// Instruction tag width, allows up to eight results in flight
`define M_ID_W 3

// One quotient bit per iteration of the restoring divider
`define M_DIV_CYCLES 32

`endif

//--- design/rv32m_pkg.sv
// RV32M execute cluster types
// Word and tag vectors, the M-extension funct3 encoding and the
// request and result bundles passed between dispatch, units and writeback

`include "rv32m_consts.svh"

package rv32m_pkg;

    typedef logic [`M_XLEN-1:0] xlen_t;      // One data word
    typedef logic [`M_ID_W-1:0] inst_id_t;   // Tag that follows an op to writeback

    // Encoded exactly as the RISC-V funct3 field of OP with funct7 = 1
    typedef enum logic [2:0] {
        MUL    = 3'b000,                    // Low word of the product
        MULH   = 3'b001,                    // High word, signed by signed
        MULHSU = 3'b010,                    // High word, signed by unsigned
        MULHU  = 3'b011,                    // High word, unsigned by unsigned
        DIV    = 3'b100,                    // Signed quotient
        DIVU   = 3'b101,                    // Unsigned quotient
        REM    = 3'b110,                    // Signed remainder
        REMU   = 3'b111                     // Unsigned remainder
    } m_funct3_e;

    // Decoded operation as it leaves issue
    typedef struct packed {
        m_funct3_e op;                      // Bit 2 picks the divider
        xlen_t     rs1;                     // First source operand
        xlen_t     rs2;                     // Second source operand
        inst_id_t  id;                      // Tag returned with the result
    } m_request_t;

    // Register file writeback bundle
    typedef struct packed {
        xlen_t    rd;                       // Value to write
        inst_id_t id;                       // Tag of the producing request
    } m_result_t;

endpackage

//--- project.f
+incdir+design
design/rv32m_pkg.sv
design/m_op_dispatch.sv
design/mul_unit.sv
design/div_unit.sv
design/m_writeback_arbiter.sv
design/m_ext_unit.sv
verification/m_ext_assert.sv
verification/m_ext_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module m_ext_tb -f project.f -o m_ext_sim

./obj_dir/m_ext_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi

//--- verification/m_ext_assert.sv
// Handshake and reset checks for the RV32M execute cluster
// Bound into the cluster top level, watches only its ports

`timescale 1ns/1ps

module m_ext_assert (
    input logic                 clk,
    input logic                 rst,
    input logic                 issue_ready,
    input logic                 result_valid,
    input logic                 result_ready,
    input rv32m_pkg::m_result_t result
);

    // Reset empties the output slot
    reset_clears_output: assert property (@(posedge clk) rst |=> !result_valid)
        else $error("result_valid high in the cycle after reset");

    // A stalled result stays put until the consumer takes it
    stalled_result_holds: assert property (@(posedge clk) disable iff (rst)
        result_valid && !result_ready |=> result_valid && $stable(result))
        else $error("result changed or dropped while stalled");

    // First cycle out of reset both units are empty and can take work
    ready_when_idle: assert property (@(posedge clk) $fell(rst) |-> issue_ready)
        else $error("issue_ready low on the first cycle out of reset");

endmodule

bind m_ext_unit m_ext_assert u_m_ext_assert (
    .clk          (clk),
    .rst          (rst),
    .issue_ready  (issue_ready),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result       (result)
);

//--- verification/m_ext_tb.sv
// Testbench for the RV32M multiply/divide execute cluster
// Runs directed corner operands for all eight ops, a fixed-latency multiply,
// and random mixed streams with and without output back-pressure.
// Results are scored by id against a reference model of the RV32M rules

`timescale 1ns/1ps
`include "rv32m_consts.svh"

module m_ext_tb;

    import rv32m_pkg::*;

    localparam int ID_COUNT = 1 << `M_ID_W;
    localparam int TIMEOUT  = 20 * `M_DIV_CYCLES;   // Cycles any single wait may take

    logic       clk;
    logic       rst;
    logic       issue_valid;
    m_request_t issue_req;
    logic       issue_ready;
    logic       result_valid;
    m_result_t  result;
    logic       result_ready;
    logic       random_ready;               // Throttles result_ready when set

    integer     seed;                       // Stimulus random state
    integer     ready_seed;                 // Back-pressure random state
    xlen_t      expected [ID_COUNT];        // Scoreboard indexed by id
    logic [ID_COUNT-1:0] busy;              // Id has a result still to come
    int         issued_count;
    int         results_seen;

    m_ext_unit u_m_ext_unit (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_req    (issue_req),
        .issue_ready  (issue_ready),
        .result_valid (result_valid),
        .result       (result),
        .result_ready (result_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // RV32M results computed from 64-bit products and plain integer division
    function automatic xlen_t ref_m_op(m_funct3_e op, xlen_t rs1, xlen_t rs2);
        logic [63:0] prod_ss;
        logic [63:0] prod_su;
        logic [63:0] prod_uu;
        logic        div_zero;
        logic        overflow;
        int          sa;
        int          sb;
        prod_ss  = {{32{rs1[31]}}, rs1} * {{32{rs2[31]}}, rs2};
        prod_su  = {{32{rs1[31]}}, rs1} * {32'h0, rs2};
        prod_uu  = {32'h0, rs1} * {32'h0, rs2};
        div_zero = (rs2 == 32'h0);
        overflow = (rs1 == 32'h8000_0000) && (rs2 == 32'hffff_ffff);
        sa = rs1;
        sb = rs2;
        case (op)
            MUL:     ref_m_op = prod_ss[31:0];
            MULH:    ref_m_op = prod_ss[63:32];
            MULHSU:  ref_m_op = prod_su[63:32];
            MULHU:   ref_m_op = prod_uu[63:32];
            DIV:     ref_m_op = div_zero ? 32'hffff_ffff : overflow ? rs1 : xlen_t'(sa / sb);
            DIVU:    ref_m_op = div_zero ? 32'hffff_ffff : rs1 / rs2;
            REM:     ref_m_op = div_zero ? rs1 : overflow ? 32'h0 : xlen_t'(sa % sb);
            default: ref_m_op = div_zero ? rs1 : rs1 % rs2;     // REMU
        endcase
    endfunction

    function automatic xlen_t corner_value(int i);
        case (i)
            0:       corner_value = 32'h0000_0000;
            1:       corner_value = 32'h0000_0001;
            2:       corner_value = 32'hffff_ffff;
            3:       corner_value = 32'h8000_0000;
            default: corner_value = 32'h7fff_ffff;
        endcase
    endfunction

    task automatic report_failure();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(string name, xlen_t got, xlen_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            report_failure();
        end
    endtask

    // Picks a free id, records the expected value and waits for the transfer
    task automatic issue_op(m_funct3_e op, xlen_t rs1, xlen_t rs2);
        logic [31:0] start;
        inst_id_t    id;
        inst_id_t    cand;
        logic        found;
        int          waited;
        found  = 1'b0;
        waited = 0;
        start  = $random(seed);
        while (!found) begin
            for (int k = 0; k < ID_COUNT; k++) begin
                cand = inst_id_t'(start + k);
                if (!found && !busy[cand]) begin
                    id    = cand;
                    found = 1'b1;
                end
            end
            if (!found) begin
                issue_valid <= 1'b0;        // Every id in flight, hold off
                @(posedge clk);
                waited++;
                if (waited > TIMEOUT) begin
                    $display("No free id appeared, results stopped coming back");
                    report_failure();
                end
            end
        end
        expected[id] = ref_m_op(op, rs1, rs2);
        busy[id]     = 1'b1;
        issued_count++;
        issue_valid <= 1'b1;
        issue_req   <= '{op: op, rs1: rs1, rs2: rs2, id: id};
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("Request with id %0d was never accepted at issue", id);
                report_failure();
            end
        end while (!issue_ready);
    endtask

    task automatic wait_idle();
        int waited;
        issue_valid <= 1'b0;
        waited = 0;
        while (busy != '0) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("Outstanding results never came back, busy ids 0x%02h", busy);
                report_failure();
            end
        end
    endtask

    task automatic run_random(int count);
        logic [31:0] pick;
        xlen_t       rs1;
        xlen_t       rs2;
        for (int n = 0; n < count; n++) begin
            pick = $random(seed);
            rs1  = $random(seed);
            rs2  = $random(seed);
            if (pick[5:4] == 2'd0) begin
                rs2 = xlen_t'(pick[11:8]);  // Small divisors, zero included
            end else if (pick[5:4] == 2'd1) begin
                rs1 = corner_value(int'(pick[14:12]));
            end
            issue_op(m_funct3_e'(pick[2:0]), rs1, rs2);
        end
        wait_idle();
    endtask

    // Each result_valid/result_ready transfer is matched against its id
    always @(posedge clk) begin
        if (!rst && result_valid && result_ready) begin
            if (!busy[result.id]) begin
                $display("Result for id %0d arrived with no request outstanding", result.id);
                report_failure();
            end else begin
                check_value($sformatf("result.rd id %0d", result.id), result.rd,
                            expected[result.id]);
                busy[result.id] = 1'b0;
                results_seen++;
            end
        end
    end

    always @(posedge clk) begin : drive_result_ready
        logic [31:0] coin;
        coin = $random(ready_seed);
        result_ready <= random_ready ? coin[0] : 1'b1;
    end

    initial begin
        int edges;
        seed         = 31;
        ready_seed   = 31;
        rst          = 1'b1;
        issue_valid  = 1'b0;
        issue_req    = '0;
        result_ready = 1'b1;
        random_ready = 1'b0;
        busy         = '0;
        issued_count = 0;
        results_seen = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Nothing issued yet, so the cluster sits in its reset state
        @(negedge clk);
        check_value("result_valid", xlen_t'(result_valid), 32'h0);
        check_value("issue_ready", xlen_t'(issue_ready), 32'h1);
        @(posedge clk);

        // All ops against every pair of corner operands
        for (int op = 0; op < 8; op++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    issue_op(m_funct3_e'(op), corner_value(i), corner_value(j));
                end
            end
        end
        wait_idle();

        // Lone MUL into an idle cluster, counted from the issue edge
        issue_op(MUL, 32'h1234_5678, 32'h9abc_def0);
        issue_valid <= 1'b0;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (edges > 10) begin
                $display("Multiply result never appeared at the output");
                report_failure();
            end
        end while (!result_valid);
        check_value("mul latency", xlen_t'(edges), 32'd3);
        @(posedge clk);
        wait_idle();

        run_random(300);                    // Output always ready
        random_ready <= 1'b1;
        run_random(300);                    // Output stalls about half the time
        random_ready <= 1'b0;
        @(negedge clk);

        // Drained cluster has an empty output slot and takes new work again
        if (results_seen == issued_count && !result_valid && issue_ready) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Cluster not idle after draining, %0d results for %0d requests",
                     results_seen, issued_count);
            report_failure();
        end
    end

endmodule
